// File: alu_pair.sv
`timescale 1ns/1ps

module alu_pair (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  iss_valid,
  input  ooo_pkg::iq_entry_t                  iss_entry [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::DISPATCH_WIDTH-1:0]  wb_valid,
  output logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] wb_tag [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::DATA_WIDTH-1:0]      wb_data [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::ROB_ADDR_WIDTH-1:0]  wb_rob_addr [ooo_pkg::DISPATCH_WIDTH]
);

  function automatic logic [ooo_pkg::DATA_WIDTH-1:0] alu(
    input ooo_pkg::alu_cmd_t              cmd,
    input logic [ooo_pkg::DATA_WIDTH-1:0] a,
    input logic [ooo_pkg::DATA_WIDTH-1:0] b
  );
    case (cmd)
      ooo_pkg::ADD: return a + b;
      ooo_pkg::SUB: return a - b;
      ooo_pkg::AND: return a & b;
      ooo_pkg::OR:  return a | b;
      ooo_pkg::XOR: return a ^ b;
      ooo_pkg::SLL: return a << b[4:0]; // shift amount is the low five bits.
      ooo_pkg::SRL: return a >> b[4:0];
      ooo_pkg::SLT: return ooo_pkg::DATA_WIDTH'($signed(a) < $signed(b));
      default:      return '0;
    endcase
  endfunction

  for (genvar l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin : g_lane
    always_ff @(posedge clk) begin
      if (rst) begin
        wb_valid[l] <= 1'b0;
      end else begin
        wb_valid[l] <= iss_valid[l];
      end
    end

    always_ff @(posedge clk) begin
      wb_tag[l]      <= iss_entry[l].phys_rd;
      wb_rob_addr[l] <= iss_entry[l].rob_addr;
      wb_data[l]     <= alu(iss_entry[l].alu_cmd, iss_entry[l].op1_val, iss_entry[l].op2_val);
    end
  end

endmodule

// File: busy_table.sv
`timescale 1ns/1ps

module busy_table (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  set_en,
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] set_tag [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  clr_en,
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] clr_tag [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] rd_tag [ooo_pkg::READ_PORTS],
  output logic [ooo_pkg::READ_PORTS-1:0]      rd_busy
);

  logic [ooo_pkg::PHYS_REGS-1:0] busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (clr_en[l]) begin
          busy[clr_tag[l]] <= 1'b0;
        end
      end
      // sets come last so a set beats a clear on the same tag.
      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (set_en[l]) begin
          busy[set_tag[l]] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < ooo_pkg::READ_PORTS; r++) begin
      rd_busy[r] = busy[rd_tag[r]];
      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (clr_en[l] && clr_tag[l] == rd_tag[r]) begin
          rd_busy[r] = 1'b0; // written back this cycle.
        end
      end
    end
  end

endmodule

// File: exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  disp_en,
  input  ooo_pkg::alu_cmd_t                   disp_alu_cmd [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] disp_op1_tag [ooo_pkg::DISPATCH_WIDTH],
  input  ooo_pkg::op_type_t                   disp_op2_type [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] disp_op2_tag [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::DATA_WIDTH-1:0]      disp_imm [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] disp_phys_rd [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::ROB_ADDR_WIDTH-1:0]  disp_rob_addr [ooo_pkg::DISPATCH_WIDTH],
  output logic                                disp_full,
  output logic [ooo_pkg::DISPATCH_WIDTH-1:0]  wb_valid,
  output logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] wb_tag [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::DATA_WIDTH-1:0]      wb_data [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::ROB_ADDR_WIDTH-1:0]  wb_rob_addr [ooo_pkg::DISPATCH_WIDTH]
);

  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] rd_tag  [ooo_pkg::READ_PORTS];
  logic [ooo_pkg::DATA_WIDTH-1:0]      rd_data [ooo_pkg::READ_PORTS];
  logic [ooo_pkg::READ_PORTS-1:0]      rd_busy;
  ooo_pkg::iq_entry_t                  disp_entry [ooo_pkg::DISPATCH_WIDTH];
  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  iss_valid;
  ooo_pkg::iq_entry_t                  iss_entry [ooo_pkg::DISPATCH_WIDTH];

  always_comb begin
    for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
      rd_tag[2*l]   = disp_op1_tag[l];
      rd_tag[2*l+1] = disp_op2_tag[l];

      disp_entry[l].alu_cmd   = disp_alu_cmd[l];
      disp_entry[l].op1_tag   = disp_op1_tag[l];
      disp_entry[l].op1_val   = rd_data[2*l];
      disp_entry[l].op1_ready = !rd_busy[2*l];
      disp_entry[l].op2_tag   = disp_op2_tag[l];
      if (disp_op2_type[l] == ooo_pkg::IMM) begin
        disp_entry[l].op2_val   = disp_imm[l];
        disp_entry[l].op2_ready = 1'b1;
      end else begin
        disp_entry[l].op2_val   = rd_data[2*l+1];
        disp_entry[l].op2_ready = !rd_busy[2*l+1];
      end
      disp_entry[l].phys_rd  = disp_phys_rd[l];
      disp_entry[l].rob_addr = disp_rob_addr[l];
    end

    // lane 1 reading lane 0's destination waits for its wakeup.
    if (disp_en[0] && disp_op1_tag[1] == disp_phys_rd[0]) begin
      disp_entry[1].op1_ready = 1'b0;
    end
    if (disp_en[0] && disp_op2_type[1] == ooo_pkg::REG && disp_op2_tag[1] == disp_phys_rd[0]) begin
      disp_entry[1].op2_ready = 1'b0;
    end
  end

  phys_reg_file u_phys_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rd_tag  (rd_tag),
    .wr_en   (wb_valid),
    .wr_tag  (wb_tag),
    .wr_data (wb_data),
    .rd_data (rd_data)
  );

  busy_table u_busy_table (
    .clk     (clk),
    .rst     (rst),
    .set_en  (disp_en),
    .set_tag (disp_phys_rd),
    .clr_en  (wb_valid),
    .clr_tag (wb_tag),
    .rd_tag  (rd_tag),
    .rd_busy (rd_busy)
  );

  issue_queue #(
    .iq_size (8)
  ) u_issue_queue (
    .clk        (clk),
    .rst        (rst),
    .disp_en    (disp_en),
    .disp_entry (disp_entry),
    .wb_valid   (wb_valid),
    .wb_tag     (wb_tag),
    .wb_data    (wb_data),
    .disp_full  (disp_full),
    .iss_valid  (iss_valid),
    .iss_entry  (iss_entry)
  );

  alu_pair u_alu_pair (
    .clk         (clk),
    .rst         (rst),
    .iss_valid   (iss_valid),
    .iss_entry   (iss_entry),
    .wb_valid    (wb_valid),
    .wb_tag      (wb_tag),
    .wb_data     (wb_data),
    .wb_rob_addr (wb_rob_addr)
  );

endmodule

// File: issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
  parameter int iq_size = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  disp_en,
  input  ooo_pkg::iq_entry_t                  disp_entry [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  wb_valid,
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] wb_tag [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::DATA_WIDTH-1:0]      wb_data [ooo_pkg::DISPATCH_WIDTH],
  output logic                                disp_full,
  output logic [ooo_pkg::DISPATCH_WIDTH-1:0]  iss_valid,
  output ooo_pkg::iq_entry_t                  iss_entry [ooo_pkg::DISPATCH_WIDTH]
);

  localparam int IDX_W = $clog2(iq_size);
  localparam int CNT_W = $clog2(iq_size + 1);

  ooo_pkg::iq_entry_t q     [iq_size]; // slot 0 is the oldest.
  ooo_pkg::iq_entry_t q_nxt [iq_size];

  logic [CNT_W-1:0]                   cnt;
  logic [CNT_W-1:0]                   cnt_nxt;
  logic [CNT_W-1:0]                   surv;
  logic [iq_size-1:0]                 rdy;
  logic [ooo_pkg::DISPATCH_WIDTH-1:0] have;
  logic [IDX_W-1:0]                   sel [ooo_pkg::DISPATCH_WIDTH];
  logic [1:0]                         n_iss;
  logic [1:0]                         n_disp;

  always_comb begin
    for (int i = 0; i < iq_size; i++) begin
      rdy[i] = (i < int'(cnt)) && q[i].op1_ready && q[i].op2_ready;
    end
  end

  // oldest-first select of up to two ready slots.
  always_comb begin
    have   = '0;
    sel[0] = '0;
    sel[1] = '0;
    for (int i = 0; i < iq_size; i++) begin
      if (rdy[i]) begin
        if (!have[0]) begin
          have[0] = 1'b1;
          sel[0]  = IDX_W'(i);
        end else if (!have[1]) begin
          have[1] = 1'b1;
          sel[1]  = IDX_W'(i);
        end
      end
    end
  end

  assign n_iss   = {1'b0, have[0]} + {1'b0, have[1]};
  assign n_disp  = {1'b0, disp_en[0]} + {1'b0, disp_en[1]};
  assign surv    = cnt - CNT_W'(n_iss);
  assign cnt_nxt = surv + CNT_W'(n_disp);

  // collapse, append and wake, all into the post-shift slot.
  always_comb begin
    int src;
    for (int j = 0; j < iq_size; j++) begin
      src = j;
      if (have[0] && j >= int'(sel[0])) begin
        src = j + 1;
      end
      if (have[1] && j + 1 >= int'(sel[1])) begin
        src = j + 2;
      end
      if (src < iq_size) begin
        q_nxt[j] = q[src];
      end else begin
        q_nxt[j] = q[j]; // beyond the tail.
      end

      if (disp_en[0] && j == int'(surv)) begin
        q_nxt[j] = disp_entry[0];
      end
      if (disp_en[1] && j == int'(surv) + 1) begin
        q_nxt[j] = disp_entry[1];
      end

      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (wb_valid[l] && !q_nxt[j].op1_ready && q_nxt[j].op1_tag == wb_tag[l]) begin
          q_nxt[j].op1_val   = wb_data[l];
          q_nxt[j].op1_ready = 1'b1;
        end
        if (wb_valid[l] && !q_nxt[j].op2_ready && q_nxt[j].op2_tag == wb_tag[l]) begin
          q_nxt[j].op2_val   = wb_data[l];
          q_nxt[j].op2_ready = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt       <= '0;
      iss_valid <= '0;
    end else begin
      cnt       <= cnt_nxt;
      iss_valid <= have;
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < iq_size; j++) begin
      q[j] <= q_nxt[j];
    end
    for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
      iss_entry[l] <= q[sel[l]];
    end
  end

  assign disp_full = int'(cnt) > iq_size - 2; // a two-wide group must always fit.

  a_no_disp_when_full: assert property (
    @(posedge clk) disable iff (rst)
    disp_full |-> (disp_en == '0)
  );

  a_lane1_needs_lane0: assert property (
    @(posedge clk) disable iff (rst)
    disp_en[1] |-> disp_en[0]
  );

endmodule

// File: list.f
ooo_pkg.sv
phys_reg_file.sv
busy_table.sv
issue_queue.sv
alu_pair.sv
exec_cluster.sv
tb_exec_cluster.sv

// File: ooo_pkg.sv
package ooo_pkg;

  localparam int DISPATCH_WIDTH  = 2;
  localparam int READ_PORTS      = 2 * DISPATCH_WIDTH; // two source reads per lane.
  localparam int PHYS_REGS       = 32;
  localparam int PHYS_ADDR_WIDTH = 5;
  localparam int DATA_WIDTH      = 32;
  localparam int ROB_ADDR_WIDTH  = 4;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SLT // signed compare.
  } alu_cmd_t;

  typedef enum logic {
    REG,
    IMM
  } op_type_t;

  // one waiting instruction; op2 of an immediate is stored ready.
  typedef struct packed {
    alu_cmd_t                    alu_cmd;
    logic [PHYS_ADDR_WIDTH-1:0]  op1_tag;
    logic [DATA_WIDTH-1:0]       op1_val;
    logic                        op1_ready;
    logic [PHYS_ADDR_WIDTH-1:0]  op2_tag;
    logic [DATA_WIDTH-1:0]       op2_val;
    logic                        op2_ready;
    logic [PHYS_ADDR_WIDTH-1:0]  phys_rd;
    logic [ROB_ADDR_WIDTH-1:0]   rob_addr;
  } iq_entry_t;

endpackage

// File: phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] rd_tag [ooo_pkg::READ_PORTS],
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]  wr_en,
  input  logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] wr_tag [ooo_pkg::DISPATCH_WIDTH],
  input  logic [ooo_pkg::DATA_WIDTH-1:0]      wr_data [ooo_pkg::DISPATCH_WIDTH],
  output logic [ooo_pkg::DATA_WIDTH-1:0]      rd_data [ooo_pkg::READ_PORTS]
);

  logic [ooo_pkg::DATA_WIDTH-1:0] regs [ooo_pkg::PHYS_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (wr_en[l]) begin
          regs[wr_tag[l]] <= wr_data[l];
        end
      end
    end
  end

  // write-through, so a dispatch in the writeback cycle sees the new value.
  always_comb begin
    for (int r = 0; r < ooo_pkg::READ_PORTS; r++) begin
      rd_data[r] = regs[rd_tag[r]];
      for (int l = 0; l < ooo_pkg::DISPATCH_WIDTH; l++) begin
        if (wr_en[l] && wr_tag[l] == rd_tag[r]) begin
          rd_data[r] = wr_data[l];
        end
      end
    end
  end

  // each destination tag is renamed fresh, so both lanes never hit one register.
  a_wr_tag_unique: assert property (
    @(posedge clk) disable iff (rst)
    (wr_en[0] && wr_en[1]) |-> (wr_tag[0] != wr_tag[1])
  );

endmodule

// File: run.sh
#!/bin/sh
# builds the exec_cluster testbench with Verilator and runs it into sim.log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exec_cluster -f list.f -o sim_exec_cluster

status=0
./obj_dir/sim_exec_cluster > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster;

  localparam int LANES    = ooo_pkg::DISPATCH_WIDTH;
  localparam int MAX_ROWS = 32;
  localparam int ROBS     = 1 << ooo_pkg::ROB_ADDR_WIDTH;

  typedef logic [ooo_pkg::PHYS_ADDR_WIDTH-1:0] tag_t;
  typedef logic [ooo_pkg::DATA_WIDTH-1:0]      data_t;
  typedef logic [ooo_pkg::ROB_ADDR_WIDTH-1:0]  rob_t;

  typedef struct packed {
    ooo_pkg::alu_cmd_t cmd;
    tag_t              op1_tag;
    ooo_pkg::op_type_t op2_type;
    tag_t              op2_tag;
    data_t             imm;
    tag_t              rd;
    rob_t              rob;
    data_t             exp_data;
    int                dep1; // producer rob in the same test, -1 for none.
    int                dep2;
  } instr_t;

  logic              clk = 1'b0;
  logic              rst;
  logic [LANES-1:0]  disp_en;
  ooo_pkg::alu_cmd_t disp_alu_cmd [LANES];
  tag_t              disp_op1_tag [LANES];
  ooo_pkg::op_type_t disp_op2_type [LANES];
  tag_t              disp_op2_tag [LANES];
  data_t             disp_imm [LANES];
  tag_t              disp_phys_rd [LANES];
  rob_t              disp_rob_addr [LANES];
  logic              disp_full;
  logic [LANES-1:0]  wb_valid;
  tag_t              wb_tag [LANES];
  data_t             wb_data [LANES];
  rob_t              wb_rob_addr [LANES];

  instr_t           tbl [MAX_ROWS][LANES];
  logic [LANES-1:0] row_en [MAX_ROWS];
  int               row_pre [MAX_ROWS]; // idle cycles before the row.
  logic             row_byp [MAX_ROWS]; // sources are written back in the dispatch cycle.
  int               test_first [8];
  string            test_name [8];
  int               n_rows;
  tag_t             next_rd;
  int               next_rob;
  data_t            model_reg [ooo_pkg::PHYS_REGS];
  int               reg_rob [ooo_pkg::PHYS_REGS];
  logic [31:0]      lfsr;

  logic  exp_valid [ROBS];
  data_t exp_data [ROBS];
  tag_t  exp_tag [ROBS];
  int    exp_dep1 [ROBS];
  int    exp_dep2 [ROBS];
  int    wb_time [ROBS];
  int    pending = 0;
  int    errors = 0;
  int    checks = 0;
  int    cyc = 0;
  int    limit = 100000;
  logic  saw_full = 1'b0;

  exec_cluster u_exec_cluster (
    .clk           (clk),
    .rst           (rst),
    .disp_en       (disp_en),
    .disp_alu_cmd  (disp_alu_cmd),
    .disp_op1_tag  (disp_op1_tag),
    .disp_op2_type (disp_op2_type),
    .disp_op2_tag  (disp_op2_tag),
    .disp_imm      (disp_imm),
    .disp_phys_rd  (disp_phys_rd),
    .disp_rob_addr (disp_rob_addr),
    .disp_full     (disp_full),
    .wb_valid      (wb_valid),
    .wb_tag        (wb_tag),
    .wb_data       (wb_data),
    .wb_rob_addr   (wb_rob_addr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("%0t: run stopped at cycle %0d, %0d writebacks never arrived", $time, cyc, pending);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic data_t ref_alu(input ooo_pkg::alu_cmd_t cmd, input data_t a, input data_t b);
    case (cmd)
      ooo_pkg::ADD: return a + b;
      ooo_pkg::SUB: return a + ~b + data_t'(1); // two's complement negate.
      ooo_pkg::AND: return a & b;
      ooo_pkg::OR:  return a | b;
      ooo_pkg::XOR: return a ^ b;
      ooo_pkg::SLL: return a << b[4:0];
      ooo_pkg::SRL: return a >> b[4:0];
      ooo_pkg::SLT: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      default:      return '0;
    endcase
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output data_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_data(input data_t got, input data_t want, input string name);
    checks++;
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t want, input string name);
    checks++;
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string name);
    checks++;
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic check_order(input int rob, input int dep);
    if (dep >= 0 && !(wb_time[dep] >= 0 && wb_time[dep] < cyc)) begin
      $display("%0t: rob_addr %0d wrote back before its producer rob_addr %0d", $time, rob, dep);
      errors++;
    end
  endtask

  always @(negedge clk) begin : wb_monitor
    int rob;
    if (!rst) begin
      for (int l = 0; l < LANES; l++) begin
        if (wb_valid[l]) begin
          rob = int'(wb_rob_addr[l]);
          if (!exp_valid[rob] || wb_time[rob] >= 0) begin
            $display("%0t: writeback for rob_addr %0d was not expected or came twice", $time, rob);
            errors++;
          end else begin
            check_data(wb_data[l], exp_data[rob], "wb_data");
            check_tag(wb_tag[l], exp_tag[rob], "wb_tag");
            check_order(rob, exp_dep1[rob]);
            check_order(rob, exp_dep2[rob]);
            wb_time[rob] = cyc;
            pending--;
          end
        end
      end
    end
  end

  task automatic start_test(input int t, input string name);
    test_first[t] = n_rows;
    test_name[t]  = name;
    next_rob      = 0;
    for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
      reg_rob[i] = -1;
    end
  endtask

  task automatic start_row(input int pre, input logic byp);
    row_en[n_rows]  = '0;
    row_pre[n_rows] = pre;
    row_byp[n_rows] = byp;
    tbl[n_rows][0]  = '0;
    tbl[n_rows][1]  = '0;
    n_rows++;
  endtask

  // appends one instruction to the open row and runs it through the model.
  task automatic add_op(input ooo_pkg::alu_cmd_t cmd, input tag_t s1,
                        input ooo_pkg::op_type_t typ, input tag_t s2, input data_t imm,
                        output tag_t rd);
    instr_t op;
    int     r;
    int     l;
    data_t  b;
    r  = n_rows - 1;
    l  = row_en[r][0] ? 1 : 0;
    b  = (typ == ooo_pkg::IMM) ? imm : model_reg[s2];
    rd = next_rd;
    op          = '0;
    op.cmd      = cmd;
    op.op1_tag  = s1;
    op.op2_type = typ;
    op.op2_tag  = (typ == ooo_pkg::IMM) ? tag_t'(0) : s2;
    op.imm      = imm;
    op.rd       = rd;
    op.rob      = rob_t'(next_rob);
    op.exp_data = ref_alu(cmd, model_reg[s1], b);
    op.dep1     = reg_rob[s1];
    op.dep2     = (typ == ooo_pkg::IMM) ? -1 : reg_rob[s2];
    model_reg[rd] = op.exp_data;
    reg_rob[rd]   = next_rob;
    tbl[r][l]     = op;
    row_en[r][l]  = 1'b1;
    next_rob++;
    next_rd = (next_rd == tag_t'(ooo_pkg::PHYS_REGS - 1)) ? tag_t'(1) : next_rd + tag_t'(1);
  endtask

  task automatic build_table();
    tag_t  s [2];
    tag_t  rd;
    data_t v;
    data_t w;
    n_rows  = 0;
    next_rd = tag_t'(1); // p0 is never written and reads as zero.
    for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
      model_reg[i] = '0;
    end

    start_test(2, "independent immediates");
    start_row(0, 1'b0);
    rand_bits(32, v);
    add_op(ooo_pkg::ADD, '0, ooo_pkg::IMM, '0, v, s[0]);
    rand_bits(32, v);
    add_op(ooo_pkg::ADD, '0, ooo_pkg::IMM, '0, v, s[1]);
    for (int c = 0; c < 8; c++) begin
      if (c % 2 == 0) begin
        start_row(0, 1'b0);
      end
      rand_bits(32, v);
      add_op(ooo_pkg::alu_cmd_t'(c[2:0]), s[c % 2], ooo_pkg::IMM, '0, v, rd);
    end

    start_test(3, "dependency chain");
    start_row(0, 1'b0);
    rand_bits(32, v);
    add_op(ooo_pkg::ADD, '0, ooo_pkg::IMM, '0, v, s[0]);
    rand_bits(32, v);
    add_op(ooo_pkg::XOR, s[0], ooo_pkg::IMM, '0, v, s[1]);
    for (int i = 0; i < 3; i++) begin
      start_row(0, 1'b0);
      rand_bits(3, w);
      add_op(ooo_pkg::alu_cmd_t'(w[2:0]), s[1], ooo_pkg::REG, s[0], '0, s[0]);
      rand_bits(3, w);
      rand_bits(32, v);
      add_op(ooo_pkg::alu_cmd_t'(w[2:0]), s[0], ooo_pkg::IMM, '0, v, s[1]);
    end

    start_test(4, "same-cycle bypass");
    start_row(0, 1'b0);
    rand_bits(32, v);
    add_op(ooo_pkg::ADD, '0, ooo_pkg::IMM, '0, v, s[0]);
    rand_bits(32, v);
    add_op(ooo_pkg::OR, '0, ooo_pkg::IMM, '0, v, s[1]);
    start_row(1, 1'b1); // lands on the producers' writeback cycle.
    add_op(ooo_pkg::SUB, s[0], ooo_pkg::REG, s[1], '0, rd);
    rand_bits(32, v);
    add_op(ooo_pkg::XOR, s[1], ooo_pkg::IMM, '0, v, rd);

    start_test(5, "queue full");
    s[0] = '0;
    for (int i = 0; i < 7; i++) begin
      start_row(0, 1'b0);
      for (int l = 0; l < LANES; l++) begin
        rand_bits(3, w);
        rand_bits(32, v);
        add_op(ooo_pkg::alu_cmd_t'(w[2:0]), s[0], ooo_pkg::IMM, '0, v, s[0]);
      end
    end

    start_test(6, "mixed groups");
    s[0] = '0;
    for (int i = 0; i < 6; i++) begin
      start_row(0, 1'b0);
      for (int l = 0; l < LANES; l++) begin
        rand_bits(10, w); // cmd, an older tag and two choice bits.
        rand_bits(32, v);
        add_op(ooo_pkg::alu_cmd_t'(w[2:0]), w[8] ? s[0] : w[7:3],
               w[9] ? ooo_pkg::REG : ooo_pkg::IMM, s[0], v, s[0]);
      end
    end
    test_first[7] = n_rows;
  endtask

  task automatic apply_row(input int r);
    repeat (row_pre[r]) @(posedge clk);
    @(negedge clk);
    while (disp_full) begin
      saw_full = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    disp_en <= row_en[r];
    for (int l = 0; l < LANES; l++) begin
      disp_alu_cmd[l]  <= tbl[r][l].cmd;
      disp_op1_tag[l]  <= tbl[r][l].op1_tag;
      disp_op2_type[l] <= tbl[r][l].op2_type;
      disp_op2_tag[l]  <= tbl[r][l].op2_tag;
      disp_imm[l]      <= tbl[r][l].imm;
      disp_phys_rd[l]  <= tbl[r][l].rd;
      disp_rob_addr[l] <= tbl[r][l].rob;
    end
    if (row_byp[r]) begin
      @(negedge clk);
      check_flag(wb_valid[0], 1'b1, "wb_valid");
    end
    @(posedge clk);
    disp_en <= '0;
  endtask

  task automatic run_test(input int t);
    int err0;
    int n;
    int rob;
    err0     = errors;
    n        = 0;
    saw_full = 1'b0;
    for (int i = 0; i < ROBS; i++) begin
      exp_valid[i] = 1'b0;
      wb_time[i]   = -1;
    end
    for (int r = test_first[t]; r < test_first[t + 1]; r++) begin
      for (int l = 0; l < LANES; l++) begin
        if (row_en[r][l]) begin
          rob            = int'(tbl[r][l].rob);
          exp_valid[rob] = 1'b1;
          exp_data[rob]  = tbl[r][l].exp_data;
          exp_tag[rob]   = tbl[r][l].rd;
          exp_dep1[rob]  = tbl[r][l].dep1;
          exp_dep2[rob]  = tbl[r][l].dep2;
          n++;
        end
      end
    end
    pending = n;
    for (int r = test_first[t]; r < test_first[t + 1]; r++) begin
      apply_row(r);
    end
    while (pending > 0) @(posedge clk);
    repeat (5) @(posedge clk); // late duplicates show up here.
    if (t == 5) begin
      check_flag(saw_full, 1'b1, "disp_full");
    end
    $display("test %0d %s: %0d writebacks, %0d errors", t, test_name[t], n, errors - err0);
  endtask

  initial begin
    int err0;
    rst     = 1'b1;
    disp_en = '0;
    for (int l = 0; l < LANES; l++) begin
      disp_alu_cmd[l]  = ooo_pkg::ADD;
      disp_op1_tag[l]  = '0;
      disp_op2_type[l] = ooo_pkg::IMM;
      disp_op2_tag[l]  = '0;
      disp_imm[l]      = '0;
      disp_phys_rd[l]  = '0;
      disp_rob_addr[l] = '0;
    end
    for (int i = 0; i < ROBS; i++) begin
      exp_valid[i] = 1'b0;
      wb_time[i]   = -1;
    end
    lfsr = 32'h88c2_25af;
    build_table();
    limit = n_rows * 40 + 100;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    err0 = errors;
    repeat (10) begin
      @(negedge clk);
      check_flag(|wb_valid, 1'b0, "wb_valid");
      check_flag(disp_full, 1'b0, "disp_full");
    end
    $display("test 1 idle after reset: %0d errors", errors - err0);
    for (int t = 2; t <= 6; t++) begin
      run_test(t);
    end

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
